// File: include/rvv_defs.svh
`ifndef RVV_DEFS_SVH
`define RVV_DEFS_SVH

// vector register geometry
`define RVV_VLEN 128
`define RVV_VLENB (`RVV_VLEN / 8)
`define RVV_NREGS 32

// major opcodes
`define RVV_OP_V 7'b1010111
`define RVV_OP_LOAD_FP 7'b0000111
`define RVV_OP_STORE_FP 7'b0100111

// minor opcodes on OP-V
`define RVV_F3_CFG 3'b111
`define RVV_F3_IVV 3'b000
`define RVV_F3_IVI 3'b011
`define RVV_F3_IVX 3'b100
`define RVV_F6_VMV 6'b010111

`endif

// File: logic/rvv_pkg.sv
`default_nettype none
`include "rvv_defs.svh"

package rvv_pkg;

	typedef logic [`RVV_VLEN-1:0] vreg_t;

	// arithmetic/config layout
	typedef struct packed {
		logic [5:0] funct6;
		logic vm;
		logic [4:0] vs2;
		logic [4:0] vs1;	// also simm/uimm
		logic [2:0] funct3;
		logic [4:0] vd;
		logic [6:0] opcode;
	} rvv_opv_t;

	// load/store layout
	typedef struct packed {
		logic [2:0] nf;
		logic mew;
		logic [1:0] mop;
		logic vm;
		logic [4:0] lumop;	// sumop on stores
		logic [4:0] rs1;
		logic [2:0] width;
		logic [4:0] vd;	// vs3 on stores
		logic [6:0] opcode;
	} rvv_mem_t;

	typedef union packed {
		rvv_opv_t opv;
		rvv_mem_t mem;
	} rvv_insn_u;

	typedef enum logic [2:0] {
		cls_none,
		cls_vsetvli,
		cls_vsetivli,
		cls_vsetvl,
		cls_load,
		cls_store,
		cls_move
	} rvv_class_e;

	typedef struct packed {
		logic vill;
		logic [22:0] reserved;
		logic vma;
		logic vta;
		logic [2:0] vsew;
		logic [2:0] vlmul;
	} rvv_vtype_t;

endpackage

`default_nettype wire

// File: logic/rvv_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvv_defs.svh"

module rvv_decoder import rvv_pkg::*; (
	input rvv_insn_u pcpi_insn_i,
	output rvv_class_e class_o,
	output logic [4:0] vd_o,
	output logic [4:0] vs1_o,
	output logic [4:0] vs2_o,
	output logic [4:0] imm_o,
	output logic [1:0] eew_o,	// 0:8 1:16 2:32 bit elements
	output logic [1:0] move_src_o	// 0 vector, 1 scalar, 2 immediate
);
	logic width_ok;
	logic unit_stride;

	assign vd_o = pcpi_insn_i.opv.vd;
	assign vs1_o = pcpi_insn_i.opv.vs1;
	assign vs2_o = pcpi_insn_i.opv.vs2;
	assign imm_o = pcpi_insn_i.opv.vs1;

	// plain unmasked unit-stride, single field
	assign unit_stride = (pcpi_insn_i.mem.nf == 3'd0) && !pcpi_insn_i.mem.mew &&
		(pcpi_insn_i.mem.mop == 2'd0) && (pcpi_insn_i.mem.lumop == 5'd0) && pcpi_insn_i.mem.vm;

	always_comb begin
		eew_o = 2'd0;
		width_ok = 1'b1;
		case (pcpi_insn_i.mem.width)
			3'b000: eew_o = 2'd0;
			3'b101: eew_o = 2'd1;
			3'b110: eew_o = 2'd2;
			default: width_ok = 1'b0;	// 64 bit and scalar fp widths
		endcase
	end

	always_comb begin
		class_o = cls_none;
		move_src_o = 2'd0;
		case (pcpi_insn_i.opv.opcode)
			`RVV_OP_V: begin
				if (pcpi_insn_i.opv.funct3 == `RVV_F3_CFG) begin
					if (!pcpi_insn_i.opv.funct6[5])
						class_o = cls_vsetvli;
					else if (pcpi_insn_i.opv.funct6[5:4] == 2'b11)
						class_o = cls_vsetivli;
					else if ({pcpi_insn_i.opv.funct6, pcpi_insn_i.opv.vm} == 7'b1000000)
						class_o = cls_vsetvl;
				end else if (pcpi_insn_i.opv.funct6 == `RVV_F6_VMV && pcpi_insn_i.opv.vm &&
						pcpi_insn_i.opv.vs2 == 5'd0) begin
					case (pcpi_insn_i.opv.funct3)
						`RVV_F3_IVV: begin
							class_o = cls_move;
							move_src_o = 2'd0;
						end
						`RVV_F3_IVX: begin
							class_o = cls_move;
							move_src_o = 2'd1;
						end
						`RVV_F3_IVI: begin
							class_o = cls_move;
							move_src_o = 2'd2;
						end
						default: ;
					endcase
				end
			end
			`RVV_OP_LOAD_FP: if (unit_stride && width_ok) class_o = cls_load;
			`RVV_OP_STORE_FP: if (unit_stride && width_ok) class_o = cls_store;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/rvv_csr.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvv_defs.svh"

module rvv_csr import rvv_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic start_i,
	input rvv_class_e class_i,
	input logic [10:0] zimm_i,
	input logic [4:0] uimm_i,
	input logic rs1_nz_i,
	input logic rd_nz_i,
	input logic [31:0] rs1_i,
	input logic [31:0] rs2_i,
	output rvv_vtype_t vtype_o,
	output logic [31:0] vl_o,
	output logic done_o
);
	localparam rvv_vtype_t VTYPE_ILLEGAL = rvv_vtype_t'(32'h8000_0000);

	rvv_vtype_t new_vtype;
	logic rsvd_bad;
	logic new_vill;
	logic [31:0] elems;	// VLEN / SEW
	logic [31:0] vlmax;
	logic [31:0] avl;

	always_comb begin
		new_vtype = '0;
		if (class_i == cls_vsetvl) begin
			new_vtype = rvv_vtype_t'(rs2_i);
		end else begin
			new_vtype.vma = zimm_i[7];
			new_vtype.vta = zimm_i[6];
			new_vtype.vsew = zimm_i[5:3];
			new_vtype.vlmul = zimm_i[2:0];
		end

		case (class_i)
			cls_vsetvl: rsvd_bad = new_vtype.vill || (|new_vtype.reserved);
			cls_vsetivli: rsvd_bad = |zimm_i[9:8];
			default: rsvd_bad = |zimm_i[10:8];
		endcase

		elems = 32'(`RVV_VLENB) >> new_vtype.vsew;
		case (new_vtype.vlmul)
			3'b100: vlmax = 32'd0;	// reserved lmul
			3'b101: vlmax = elems >> 3;
			3'b110: vlmax = elems >> 2;
			3'b111: vlmax = elems >> 1;
			default: vlmax = elems << new_vtype.vlmul[1:0];
		endcase

		// 64 bit and wider sew not supported
		new_vill = rsvd_bad || (new_vtype.vsew > 3'd2) || (vlmax == 32'd0);

		if (class_i == cls_vsetivli)
			avl = {27'd0, uimm_i};
		else if (rs1_nz_i)
			avl = rs1_i;
		else if (rd_nz_i)
			avl = '1;	// request vlmax
		else
			avl = vl_o;	// keep current vl
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			vtype_o <= VTYPE_ILLEGAL;
			vl_o <= 32'd0;
		end else if (start_i) begin
			if (new_vill) begin
				vtype_o <= VTYPE_ILLEGAL;
				vl_o <= 32'd0;
			end else begin
				vtype_o <= new_vtype;
				vl_o <= (avl < vlmax) ? avl : vlmax;
			end
		end
	end

	assign done_o = start_i;	// single cycle update

endmodule

`default_nettype wire

// File: logic/rvv_vregs.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvv_defs.svh"

module rvv_vregs import rvv_pkg::*; (
	input logic clk,
	input logic wen_i,
	input logic [4:0] waddr_i,
	input vreg_t wdata_i,
	input logic [4:0] raddr1_i,
	input logic [4:0] raddr2_i,
	output vreg_t rdata1_o,
	output vreg_t rdata2_o
);
	vreg_t regs [`RVV_NREGS];

	always_ff @(posedge clk) begin
		if (wen_i) regs[waddr_i] <= wdata_i;
	end

	// asynchronous read ports
	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

endmodule

`default_nettype wire

// File: logic/rvv_lsu.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvv_defs.svh"

module rvv_lsu import rvv_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic start_i,
	input logic store_i,
	input logic [1:0] eew_i,
	input logic [4:0] vd_i,
	input logic [31:0] base_i,
	input logic [31:0] vl_i,
	input logic vill_i,
	input vreg_t vreg_rdata_i,
	output logic [4:0] vreg_raddr_o,
	output logic [4:0] vreg_waddr_o,
	output logic vreg_wen_o,
	output vreg_t vreg_wdata_o,
	output logic mem_req_o,
	output logic mem_we_o,
	output logic [31:0] mem_addr_o,
	output logic [31:0] mem_wdata_o,
	output logic [3:0] mem_strb_o,
	input logic [31:0] mem_rdata_i,
	input logic mem_done_i,
	output logic done_o
);
	localparam int VLENB_SH = $clog2(`RVV_VLENB);

	logic active;	// elements still to transfer
	logic req_q;
	logic [31:0] idx;	// current element
	logic empty;
	logic last;
	logic [2:0] elem_sh;	// log2 of elements per register
	logic [31:0] reg_ofs;
	logic [VLENB_SH-1:0] byte_pos;
	logic [31:0] addr;
	logic [1:0] lane;
	logic [3:0] strb_base;
	logic [31:0] elem_bits;
	logic [31:0] mem_elem;
	logic [31:0] st_elem;

	assign empty = vill_i || (vl_i == 32'd0);
	assign last = (idx + 32'd1 == vl_i);

	// element index to register and byte position
	assign elem_sh = 3'(VLENB_SH) - {1'b0, eew_i};
	assign reg_ofs = idx >> elem_sh;
	assign byte_pos = VLENB_SH'((idx & ((32'd1 << elem_sh) - 32'd1)) << eew_i);

	assign addr = base_i + (idx << eew_i);
	assign lane = addr[1:0];	// aligned by requirement

	always_comb begin
		case (eew_i)
			2'd0: begin
				strb_base = 4'b0001;
				elem_bits = 32'h0000_00ff;
			end
			2'd1: begin
				strb_base = 4'b0011;
				elem_bits = 32'h0000_ffff;
			end
			default: begin
				strb_base = 4'b1111;
				elem_bits = 32'hffff_ffff;
			end
		endcase
	end

	assign vreg_raddr_o = vd_i + reg_ofs[4:0];
	assign vreg_waddr_o = vreg_raddr_o;	// load is read-modify-write of the same register

	// load path: merge the addressed lanes into the register
	assign mem_elem = (mem_rdata_i >> {lane, 3'b000}) & elem_bits;
	assign vreg_wdata_o = (vreg_rdata_i & ~(vreg_t'(elem_bits) << {byte_pos, 3'b000})) |
		(vreg_t'(mem_elem) << {byte_pos, 3'b000});
	assign vreg_wen_o = req_q && !store_i && mem_done_i;

	// store path: element moved onto its byte lanes
	assign st_elem = 32'(vreg_rdata_i >> {byte_pos, 3'b000}) & elem_bits;
	assign mem_wdata_o = st_elem << {lane, 3'b000};
	assign mem_strb_o = strb_base << lane;

	assign mem_req_o = req_q;
	assign mem_we_o = req_q && store_i;
	assign mem_addr_o = addr;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			req_q <= 1'b0;
			idx <= 32'd0;
		end else if (start_i) begin
			idx <= 32'd0;
			active <= !empty;
			req_q <= !empty;
		end else if (req_q) begin
			if (mem_done_i) begin
				req_q <= 1'b0;	// one idle cycle between elements
				idx <= idx + 32'd1;
				if (last) active <= 1'b0;
			end
		end else if (active) begin
			req_q <= 1'b1;
		end
	end

	// vill or vl = 0 finishes at once
	assign done_o = (start_i && empty) || (req_q && mem_done_i && last);

endmodule

`default_nettype wire

// File: logic/rvv_move_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rvv_defs.svh"

module rvv_move_unit import rvv_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic start_i,
	input logic [1:0] src_i,
	input logic [4:0] vd_i,
	input logic [4:0] vs1_i,
	input logic [4:0] imm_i,
	input logic [31:0] rs1_i,
	input rvv_vtype_t vtype_i,
	input logic [31:0] vl_i,
	input vreg_t vreg_rdata1_i,
	input vreg_t vreg_rdata2_i,
	output logic [4:0] vreg_raddr1_o,
	output logic [4:0] vreg_raddr2_o,
	output logic vreg_wen_o,
	output vreg_t vreg_wdata_o,
	output logic done_o
);
	logic active;
	logic [2:0] k;	// register within the group
	logic [31:0] remaining;	// body elements not yet written
	logic [2:0] group_max;
	logic [31:0] epr;	// elements per register
	logic [31:0] body_bits;
	logic [31:0] scalar;
	vreg_t splat;
	vreg_t src_data;
	vreg_t body_mask;

	// fractional lmul still occupies one register
	assign group_max = vtype_i.vlmul[2] ? 3'd0 : 3'((4'd1 << vtype_i.vlmul[1:0]) - 4'd1);
	assign epr = 32'(`RVV_VLENB) >> vtype_i.vsew;
	assign body_bits = remaining << ({2'b00, vtype_i.vsew} + 5'd3);

	assign scalar = (src_i == 2'd2) ? {27'd0, imm_i} : rs1_i;

	always_comb begin
		case (vtype_i.vsew)
			3'd0: splat = {`RVV_VLENB{scalar[7:0]}};
			3'd1: splat = {(`RVV_VLENB / 2){scalar[15:0]}};
			default: splat = {(`RVV_VLENB / 4){scalar}};
		endcase
	end

	assign src_data = (src_i == 2'd0) ? vreg_rdata1_i : splat;
	assign body_mask = (body_bits >= 32'(`RVV_VLEN)) ? '1 : ~({`RVV_VLEN{1'b1}} << body_bits);

	assign vreg_raddr1_o = vs1_i + {2'b00, k};
	assign vreg_raddr2_o = vd_i + {2'b00, k};	// old contents for the tail
	assign vreg_wdata_o = (src_data & body_mask) | (vreg_rdata2_i & ~body_mask);
	assign vreg_wen_o = active;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			k <= 3'd0;
			remaining <= 32'd0;
		end else if (start_i) begin
			active <= 1'b1;
			k <= 3'd0;
			remaining <= vl_i;
		end else if (active) begin
			k <= k + 3'd1;
			remaining <= (remaining > epr) ? remaining - epr : 32'd0;
			if (k == group_max) active <= 1'b0;
		end
	end

	assign done_o = active && (k == group_max);

endmodule

`default_nettype wire

// File: logic/rvv_coproc.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_coproc import rvv_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic pcpi_valid_i,
	input logic [31:0] pcpi_insn_i,
	input logic [31:0] pcpi_rs1_i,
	input logic [31:0] pcpi_rs2_i,
	output logic pcpi_ready_o,
	output logic pcpi_wr_o,
	output logic pcpi_wait_o,
	output logic pcpi_is_rvv_o,
	output logic [31:0] pcpi_rd_o,
	output logic mem_req_o,
	output logic mem_we_o,
	output logic [31:0] mem_addr_o,
	output logic [31:0] mem_wdata_o,
	output logic [3:0] mem_strb_o,
	input logic [31:0] mem_rdata_i,
	input logic mem_done_i
);
	rvv_insn_u insn;
	rvv_class_e cls;
	logic [4:0] vd, vs1, vs2, imm;
	logic [1:0] eew, move_src;
	rvv_vtype_t vtype;
	logic [31:0] vl;
	logic busy;	// instruction already started
	logic start;
	logic is_cfg, is_mem, is_move;
	logic csr_done, lsu_done, mv_done, done_any;
	logic rf_wen;
	logic [4:0] rf_waddr, rf_raddr1, rf_raddr2;
	vreg_t rf_wdata, rf_rdata1, rf_rdata2;
	logic lsu_wen;
	logic [4:0] lsu_raddr, lsu_waddr;
	vreg_t lsu_wdata;
	logic mv_wen;
	logic [4:0] mv_raddr1, mv_raddr2;
	vreg_t mv_wdata;

	assign insn = pcpi_insn_i;

	rvv_decoder decoder_inst (
		.pcpi_insn_i(insn), .class_o(cls), .vd_o(vd), .vs1_o(vs1), .vs2_o(vs2),
		.imm_o(imm), .eew_o(eew), .move_src_o(move_src)
	);

	assign is_cfg = cls inside {cls_vsetvli, cls_vsetivli, cls_vsetvl};
	assign is_mem = cls inside {cls_load, cls_store};
	assign is_move = (cls == cls_move);
	assign pcpi_is_rvv_o = (cls != cls_none);
	assign start = pcpi_valid_i && !busy && pcpi_is_rvv_o;
	assign done_any = csr_done || lsu_done || mv_done;

	rvv_csr csr_inst (
		.clk(clk), .resetn(resetn), .start_i(start && is_cfg), .class_i(cls),
		.zimm_i({insn.opv.funct6[4:0], insn.opv.vm, vs2}), .uimm_i(imm),
		.rs1_nz_i(vs1 != 5'd0), .rd_nz_i(vd != 5'd0),
		.rs1_i(pcpi_rs1_i), .rs2_i(pcpi_rs2_i),
		.vtype_o(vtype), .vl_o(vl), .done_o(csr_done)
	);

	rvv_lsu lsu_inst (
		.clk(clk), .resetn(resetn), .start_i(start && is_mem), .store_i(cls == cls_store),
		.eew_i(eew), .vd_i(vd), .base_i(pcpi_rs1_i), .vl_i(vl), .vill_i(vtype.vill),
		.vreg_rdata_i(rf_rdata1), .vreg_raddr_o(lsu_raddr), .vreg_waddr_o(lsu_waddr),
		.vreg_wen_o(lsu_wen), .vreg_wdata_o(lsu_wdata),
		.mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
		.mem_wdata_o(mem_wdata_o), .mem_strb_o(mem_strb_o), .mem_rdata_i(mem_rdata_i),
		.mem_done_i(mem_done_i), .done_o(lsu_done)
	);

	rvv_move_unit move_inst (
		.clk(clk), .resetn(resetn), .start_i(start && is_move), .src_i(move_src),
		.vd_i(vd), .vs1_i(vs1), .imm_i(imm), .rs1_i(pcpi_rs1_i), .vtype_i(vtype), .vl_i(vl),
		.vreg_rdata1_i(rf_rdata1), .vreg_rdata2_i(rf_rdata2),
		.vreg_raddr1_o(mv_raddr1), .vreg_raddr2_o(mv_raddr2),
		.vreg_wen_o(mv_wen), .vreg_wdata_o(mv_wdata), .done_o(mv_done)
	);

	// register file goes to whichever unit owns the class
	assign rf_raddr1 = is_move ? mv_raddr1 : lsu_raddr;
	assign rf_raddr2 = mv_raddr2;
	assign rf_wen = is_move ? mv_wen : (is_mem && lsu_wen);
	assign rf_waddr = is_move ? mv_raddr2 : lsu_waddr;	// move writes vd + k
	assign rf_wdata = is_move ? mv_wdata : lsu_wdata;

	rvv_vregs vregs_inst (
		.clk(clk), .wen_i(rf_wen), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
		.raddr1_i(rf_raddr1), .raddr2_i(rf_raddr2), .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2)
	);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			pcpi_ready_o <= 1'b0;
			pcpi_wr_o <= 1'b0;
			pcpi_wait_o <= 1'b0;
		end else begin
			if (!pcpi_valid_i) busy <= 1'b0;	// core drops valid between instructions
			else if (start) busy <= 1'b1;
			pcpi_ready_o <= done_any;
			pcpi_wr_o <= csr_done;
			pcpi_wait_o <= pcpi_valid_i && (start || busy) && !done_any && !pcpi_ready_o;
		end
	end

	// vl register already holds the new value when ready rises
	assign pcpi_rd_o = vl;

endmodule

`default_nettype wire

// File: verification/rvv_coproc_props.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_coproc_props (
	input logic clk,
	input logic resetn,
	input logic pcpi_ready_o,
	input logic pcpi_wr_o,
	input logic mem_req_o,
	input logic mem_we_o,
	input logic [31:0] mem_addr_o,
	input logic [31:0] mem_wdata_o,
	input logic [3:0] mem_strb_o,
	input logic mem_done_i
);
	// request held until the memory answers
	assert property (@(posedge clk) disable iff (!resetn)
		mem_req_o && !mem_done_i |=> mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o)
		&& $stable(mem_wdata_o) && $stable(mem_strb_o))
		else $error("memory request changed before done");

	assert property (@(posedge clk) disable iff (!resetn) pcpi_ready_o |=> !pcpi_ready_o)
		else $error("ready longer than one cycle");

	assert property (@(posedge clk) disable iff (!resetn) pcpi_wr_o |-> pcpi_ready_o)
		else $error("wr without ready");

	assert property (@(posedge clk) disable iff (!resetn) pcpi_ready_o |-> !mem_req_o)
		else $error("memory request during ready");

endmodule

bind rvv_coproc rvv_coproc_props props_inst (
	.clk(clk), .resetn(resetn), .pcpi_ready_o(pcpi_ready_o), .pcpi_wr_o(pcpi_wr_o),
	.mem_req_o(mem_req_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
	.mem_wdata_o(mem_wdata_o), .mem_strb_o(mem_strb_o), .mem_done_i(mem_done_i)
);

`default_nettype wire

// File: verification/rvv_coproc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_coproc_tb;
	localparam int TIMEOUT = 400;	// cycles per instruction
	localparam int NWORDS = 256;

	logic clk, resetn, pcpi_valid;
	logic [31:0] pcpi_insn, pcpi_rs1, pcpi_rs2, pcpi_rd;
	logic pcpi_ready, pcpi_wr, pcpi_wait, pcpi_is_rvv;
	logic mem_req, mem_we;
	logic [31:0] mem_addr, mem_wdata;
	logic [3:0] mem_strb;
	logic [31:0] mem_rdata = 32'd0;
	logic mem_done = 1'b0;
	logic [31:0] stim [NWORDS];
	logic [7:0] mem [logic [31:0]];	// written bytes only
	logic [127:0] mreg [32];	// expected register contents
	logic [31:0] st_addr [$];
	logic [31:0] st_data [$];
	logic [3:0] st_strb [$];
	int req_count = 0;
	int delay;
	int mvl, msew, mlmul, errs, fails, passes;
	logic timed_out;

	rvv_coproc rvv_coproc_inst (
		.clk(clk), .resetn(resetn), .pcpi_valid_i(pcpi_valid), .pcpi_insn_i(pcpi_insn),
		.pcpi_rs1_i(pcpi_rs1), .pcpi_rs2_i(pcpi_rs2), .pcpi_ready_o(pcpi_ready),
		.pcpi_wr_o(pcpi_wr), .pcpi_wait_o(pcpi_wait), .pcpi_is_rvv_o(pcpi_is_rvv),
		.pcpi_rd_o(pcpi_rd), .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
		.mem_wdata_o(mem_wdata), .mem_strb_o(mem_strb), .mem_rdata_i(mem_rdata),
		.mem_done_i(mem_done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [7:0] mem_byte(input logic [31:0] a);
		logic [31:0] v;
		if (mem.exists(a)) return mem[a];
		v = a * 32'd7 + 32'd3;	// untouched fill
		return v[7:0];
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] a);
		logic [31:0] w;
		for (int j = 0; j < 4; j++) w[j*8 +: 8] = mem_byte({a[31:2], 2'b00} + 32'(j));
		return w;
	endfunction

	function automatic int elem_bytes(input logic [31:0] insn);
		case (insn[14:12])
			3'b000: return 1;
			3'b101: return 2;
			default: return 4;
		endcase
	endfunction

	// byte position within a register group
	function automatic logic [7:0] model_byte(input int vd, input int flat);
		return mreg[(vd + flat / 16) % 32][(flat % 16) * 8 +: 8];
	endfunction

	task automatic set_model_byte(input int vd, input int flat, input logic [7:0] b);
		mreg[(vd + flat / 16) % 32][(flat % 16) * 8 +: 8] = b;
	endtask

	// memory side, done after 0 to 3 extra cycles
	always @(posedge clk) begin
		if (!resetn) begin
			mem_done <= 1'b0;
			delay <= 0;
		end else if (mem_done) begin
			mem_done <= 1'b0;
		end else if (mem_req) begin
			if (delay == 0) begin
				mem_done <= 1'b1;
				mem_rdata <= read_word(mem_addr);
				req_count++;
				if (mem_we) begin
					st_addr.push_back(mem_addr);
					st_data.push_back(mem_wdata);
					st_strb.push_back(mem_strb);
					for (int j = 0; j < 4; j++)
						if (mem_strb[j]) mem[{mem_addr[31:2], 2'b00} + 32'(j)] = mem_wdata[j*8 +: 8];
				end
				delay <= int'($urandom % 4);
			end else begin
				delay <= delay - 1;
			end
		end
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
			errs++;
		end
	endtask

	task automatic issue(input logic [31:0] insn, input logic [31:0] rs1, input logic [31:0] rs2,
			output int cycles, output logic [31:0] rd, output logic wr);
		int n;
		logic exp_wait;
		n = 0;
		@(posedge clk);
		pcpi_valid <= 1'b1;
		pcpi_insn <= insn;
		pcpi_rs1 <= rs1;
		pcpi_rs2 <= rs2;
		while (n < TIMEOUT) begin
			@(negedge clk);
			n++;
			if (n == 1) check("pcpi_is_rvv_o", 32'd1, {31'd0, pcpi_is_rvv});
			exp_wait = (n >= 2) && !pcpi_ready;	// from valid seen until ready
			check("pcpi_wait_o", {31'd0, exp_wait}, {31'd0, pcpi_wait});
			if (pcpi_ready) break;
		end
		if (!pcpi_ready) begin
			$display("timeout: no ready for instruction %h", insn);
			timed_out = 1'b1;
		end else begin
			cycles = n;
			rd = pcpi_rd;
			wr = pcpi_wr;
			@(posedge clk);
			pcpi_valid <= 1'b0;
			@(posedge clk);	// idle cycle between instructions
		end
	endtask

	task automatic check_store(input logic [31:0] insn, input logic [31:0] base, input int c0,
			input int q0);
		int eb, vd;
		logic [31:0] a, w;
		logic [3:0] s;
		eb = elem_bytes(insn);
		vd = int'(insn[11:7]);
		check("store request count", 32'(mvl), 32'(req_count - c0));
		check("mem_we_o store count", 32'(mvl), 32'(st_addr.size() - q0));
		for (int i = 0; i < mvl && q0 + i < st_addr.size(); i++) begin
			a = base + 32'(i * eb);
			w = 32'd0;
			s = 4'd0;
			for (int j = 0; j < eb; j++) begin
				w[(int'(a[1:0]) + j) * 8 +: 8] = model_byte(vd, i * eb + j);
				s[int'(a[1:0]) + j] = 1'b1;
			end
			check("mem_addr_o", a, st_addr[q0 + i]);
			check("mem_wdata_o", w, st_data[q0 + i]);
			check("mem_strb_o", {28'd0, s}, {28'd0, st_strb[q0 + i]});
		end
	endtask

	task automatic model_move(input logic [31:0] insn, input logic [31:0] rs1, input int group);
		int eb, epr, idx, vd, vs1;
		logic [31:0] scalar;
		logic [7:0] b;
		eb = 1 << msew;
		epr = 16 / eb;
		vd = int'(insn[11:7]);
		vs1 = int'(insn[19:15]);
		scalar = (insn[14:12] == 3'b011) ? {27'd0, insn[19:15]} : rs1;
		for (int k = 0; k < group; k++)
			for (int e = 0; e < epr; e++) begin
				idx = k * epr + e;
				if (idx < mvl)
					for (int j = 0; j < eb; j++) begin
						b = (insn[14:12] == 3'b000) ? model_byte(vs1, idx * eb + j) : scalar[j*8 +: 8];
						set_model_byte(vd, idx * eb + j, b);
					end
			end
	endtask

	task automatic run_test(input int t);
		logic [31:0] tag, insn, rs1, rs2, exp, rd;
		logic wr;
		int cycles, c0, q0, group;
		tag = stim[t*5];
		insn = stim[t*5 + 1];
		rs1 = stim[t*5 + 2];
		rs2 = stim[t*5 + 3];
		exp = stim[t*5 + 4];
		errs = 0;
		c0 = req_count;
		q0 = st_addr.size();
		issue(insn, rs1, rs2, cycles, rd, wr);
		if (timed_out) begin
			errs++;
		end else begin
			case (tag)
				32'd1: begin
					check("pcpi_rd_o", exp, rd);
					check("pcpi_wr_o", 32'd1, {31'd0, wr});
					check("vset ready cycles", 32'd2, 32'(cycles));
					mvl = int'(exp);
					msew = int'(insn[25:23]);
					mlmul = int'(insn[22:20]);
				end
				32'd2: begin
					check("load request count", 32'(mvl), 32'(req_count - c0));
					check("mem_we_o store count", 32'd0, 32'(st_addr.size() - q0));
					for (int f = 0; f < mvl * elem_bytes(insn); f++)
						set_model_byte(int'(insn[11:7]), f, mem_byte(rs1 + 32'(f)));
				end
				32'd3: check_store(insn, rs1, c0, q0);
				default: begin
					group = (mlmul >= 4) ? 1 : (1 << mlmul);	// fractional uses one register
					check("move ready cycles", 32'(group + 2), 32'(cycles));
					model_move(insn, rs1, group);
				end
			endcase
			if (tag != 32'd1) check("pcpi_wr_o", 32'd0, {31'd0, wr});
		end
		$display("test %0d tag %0d insn %h: %s", t, tag, insn, (errs == 0) ? "ok" : "failed");
		if (errs == 0) passes++;
		else fails++;
	endtask

	initial begin
		void'($urandom(35));
		resetn = 1'b0;
		pcpi_valid = 1'b0;
		pcpi_insn = 32'd0;
		pcpi_rs1 = 32'd0;
		pcpi_rs2 = 32'd0;
		mvl = 0;
		msew = 0;
		mlmul = 0;
		fails = 0;
		passes = 0;
		timed_out = 1'b0;
		for (int i = 0; i < 32; i++) mreg[i] = '0;
		for (int i = 0; i < NWORDS; i++) stim[i] = 32'd0;
		$readmemh("verification/rvv_stimulus.txt", stim);
		repeat (4) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);
		for (int t = 0; t * 5 < NWORDS && stim[t*5] != 32'd0 && !timed_out; t++) run_test(t);
		$display("tests run %0d, passed %0d, failed %0d", passes + fails, passes, fails);
		if (fails == 0 && passes > 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: rvv_coproc.f
+incdir+include
logic/rvv_pkg.sv
logic/rvv_decoder.sv
logic/rvv_csr.sv
logic/rvv_vregs.sv
logic/rvv_lsu.sv
logic/rvv_move_unit.sv
logic/rvv_coproc.sv
verification/rvv_coproc_props.sv
verification/rvv_coproc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the rvv_coproc testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rvv_coproc.f --top-module rvv_coproc_tb -o rvv_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/rvv_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

// File: verification/rvv_stimulus.txt
// columns: tag (1 vset, 2 load, 3 store, 4 move), insn, rs1, rs2, expected vl
// load/store take the base address in rs1; expected column unused there
00000003 020160A7 00000100 00000000 00000000
00000001 010170D7 0000000A 00000000 00000004
00000001 007170D7 00000014 00000000 00000008
00000001 009170D7 00000005 00000000 00000005
00000001 014170D7 00000004 00000000 00000000
00000001 C121F0D7 00000000 00000000 00000003
00000001 010170D7 00000004 00000000 00000004
00000002 02016087 00000040 00000000 00000000
00000003 020160A7 00000200 00000000 00000000
00000001 000170D7 00000007 00000000 00000007
00000003 020100A7 00000301 00000000 00000000
00000001 008170D7 00000006 00000000 00000006
00000003 020150A7 00000402 00000000 00000000
00000001 009170D7 00000010 00000000 00000010
00000002 02015107 00000080 00000000 00000000
00000001 009170D7 0000000B 00000000 0000000B
00000004 5E01C157 0000A5B6 00000000 00000000
00000001 009170D7 00000010 00000000 00000010
00000003 02015127 00000500 00000000 00000000
00000001 001170D7 00000020 00000000 00000020
00000002 02010207 000000C0 00000000 00000000
00000001 001170D7 00000014 00000000 00000014
00000004 5E06B257 00000000 00000000 00000000
00000001 001170D7 00000020 00000000 00000020
00000003 02010227 00000600 00000000 00000000
00000001 010170D7 00000004 00000000 00000004
00000002 02016307 00000700 00000000 00000000
00000004 5E030457 00000000 00000000 00000000
00000003 020164A7 00000800 00000000 00000000
00000000 00000000 00000000 00000000 00000000
